//--- common/dcache_pkg.sv
// Data cache shared geometry, field types, miss record and miss FSM states
`default_nettype none

package dcache_pkg;

	// Cache geometry, 8 KB in all
	localparam int num_sets = 32;
	localparam int num_ways = 4;
	localparam int line_bytes = 64;
	localparam int fifo_depth = 4;

	typedef logic [31:0] addr_t;
	typedef logic [20:0] tag_t;
	typedef logic [$clog2(num_sets)-1:0] set_idx_t;
	typedef logic [$clog2(num_ways)-1:0] way_idx_t;
	typedef logic [line_bytes*8-1:0] line_t;
	// Bit n enables byte n of the line
	typedef logic [line_bytes-1:0] byte_mask_t;
	// Tree state, decoded in pseudo_lru
	typedef logic [2:0] lru_bits_t;

	// One pending miss, queued between tag stage and miss controller
	typedef struct packed {
		tag_t victim_tag;
		tag_t req_tag;
		way_idx_t victim_way;
		set_idx_t set_idx;
		logic victim_dirty;
	} miss_rec_t;

	typedef enum logic [1:0] {
		idle,
		l2_write,
		l2_read
	} miss_state_t;

endpackage

`default_nettype wire

//--- common/dcache_if.sv
// Internal data cache buses for hit lookup, miss enqueue and line fill
`timescale 1ns/10ps
`default_nettype none

// Hit from tag stage to data stage, one cycle after the access
interface lookup_if import dcache_pkg::*; ();
	logic hit_valid;
	logic write;
	way_idx_t way;
	set_idx_t set_idx;
	line_t wdata;
	byte_mask_t mask;

	modport source(output hit_valid, write, way, set_idx, wdata, mask);
	modport sink(input hit_valid, write, way, set_idx, wdata, mask);
endinterface

interface miss_if import dcache_pkg::*; ();
	logic enqueue;
	miss_rec_t rec;

	modport source(output enqueue, rec);
	modport sink(input enqueue, rec);
endinterface

// Driven by the miss controller, except the victim line
interface fill_if import dcache_pkg::*; ();
	set_idx_t set_idx;
	way_idx_t way;
	logic line_write;
	line_t fill_line;
	line_t victim_line;
	logic fill_start;
	logic fill_done;
	tag_t fill_tag;

	modport source(output set_idx, way, line_write, fill_line, fill_start, fill_done, fill_tag,
		input victim_line);
	modport line_xfer(input set_idx, way, line_write, fill_line, output victim_line);
	modport bookkeep(input set_idx, way, fill_start, fill_done, fill_tag);
endinterface

`default_nettype wire

//--- dcache/pseudo_lru.sv
// Tree pseudo-LRU for four ways, picks the victim and updates the tree bits
`timescale 1ns/10ps
`default_nettype none

module pseudo_lru import dcache_pkg::*;
(
	input wire lru_bits_t lru_bits_i,
	input wire way_idx_t access_way_i,
	output way_idx_t victim_way_o,
	output lru_bits_t lru_bits_o
);

	// Bit 0 picks the pair, bit 1 or bit 2 the way within it
	always_comb
	begin
		if (lru_bits_i[0])
			victim_way_o = {1'b1, lru_bits_i[2]};
		else
			victim_way_o = {1'b0, lru_bits_i[1]};
	end

	// Point every bit on the accessed path away from that way
	always_comb
	begin
		lru_bits_o = lru_bits_i;
		if (access_way_i[1])
		begin
			lru_bits_o[0] = 1'b0;
			lru_bits_o[2] = !access_way_i[0];
		end
		else
		begin
			lru_bits_o[0] = 1'b1;
			lru_bits_o[1] = !access_way_i[0];
		end
	end

endmodule

`default_nettype wire

//--- dcache/dcache_tag_stage.sv
// Data cache tag stage with tag, valid, dirty and LRU state, hit check and miss records
`timescale 1ns/10ps
`default_nettype none

module dcache_tag_stage import dcache_pkg::*;
(
	input wire clk,
	input wire reset_i,
	input wire addr_t address_i,
	input wire access_i,
	input wire write_i,
	input wire byte_mask_t write_mask_i,
	input wire line_t data_i,
	output logic cache_hit_o,
	lookup_if.source lookup,
	miss_if.source miss,
	fill_if.bookkeep fill
);

	set_idx_t req_set;
	tag_t req_tag;

	// Per-way state, indexed by set
	tag_t tag_mem [num_ways][num_sets];
	logic [num_sets-1:0] valid_q [num_ways];
	logic [num_sets-1:0] dirty_q [num_ways];
	lru_bits_t lru_q [num_sets];

	// Request and set contents as seen in cycle 1
	logic access_q;
	logic write_q;
	set_idx_t set_q;
	tag_t tag_q;
	line_t data_q;
	byte_mask_t mask_q;
	tag_t tag_rd [num_ways];
	logic [num_ways-1:0] valid_rd;
	lru_bits_t lru_rd;

	logic [num_ways-1:0] way_hit;
	logic hit_any;
	way_idx_t hit_way;
	way_idx_t victim_way;
	way_idx_t touch_way;
	lru_bits_t lru_next;

	assign req_set = address_i[10:6];
	assign req_tag = address_i[31:11];

	always_ff @(posedge clk)
	begin
		for (int w = 0; w < num_ways; w++)
		begin
			tag_rd[w] <= tag_mem[w][req_set];
			valid_rd[w] <= valid_q[w][req_set];
		end
		// Back-to-back access to one set sees the pending LRU update
		if (access_q && set_q == req_set)
			lru_rd <= lru_next;
		else
			lru_rd <= lru_q[req_set];
		write_q <= write_i;
		set_q <= req_set;
		tag_q <= req_tag;
		data_q <= data_i;
		mask_q <= write_mask_i;
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
			access_q <= 1'b0;
		else
			access_q <= access_i;
	end

	// Tag compare, lowest matching way wins
	always_comb
	begin
		hit_way = '0;
		for (int w = num_ways - 1; w >= 0; w--)
		begin
			way_hit[w] = valid_rd[w] && tag_rd[w] == tag_q;
			if (way_hit[w])
				hit_way = way_idx_t'(w);
		end
	end

	assign hit_any = |way_hit;
	assign cache_hit_o = access_q && hit_any;
	// A missed victim becomes most recently used too
	assign touch_way = hit_any ? hit_way : victim_way;

	pseudo_lru lru_i (
		.lru_bits_i(lru_rd),
		.access_way_i(touch_way),
		.victim_way_o(victim_way),
		.lru_bits_o(lru_next)
	);

	assign lookup.hit_valid = cache_hit_o;
	assign lookup.write = write_q;
	assign lookup.way = hit_way;
	assign lookup.set_idx = set_q;
	assign lookup.wdata = data_q;
	assign lookup.mask = mask_q;

	assign miss.enqueue = access_q && !hit_any;
	assign miss.rec = '{
		victim_tag: tag_rd[victim_way],
		req_tag: tag_q,
		victim_way: victim_way,
		set_idx: set_q,
		victim_dirty: valid_rd[victim_way] && dirty_q[victim_way][set_q]
	};

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			for (int w = 0; w < num_ways; w++)
			begin
				valid_q[w] <= '0;
				dirty_q[w] <= '0;
			end
			for (int s = 0; s < num_sets; s++)
				lru_q[s] <= '0;
		end
		else
		begin
			if (access_q)
				lru_q[set_q] <= lru_next;
			if (cache_hit_o && write_q)
				dirty_q[hit_way][set_q] <= 1'b1;
			// Way is unusable while its line is being replaced
			if (fill.fill_start)
				valid_q[fill.way][fill.set_idx] <= 1'b0;
			if (fill.fill_done)
			begin
				valid_q[fill.way][fill.set_idx] <= 1'b1;
				dirty_q[fill.way][fill.set_idx] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (fill.fill_done)
			tag_mem[fill.way][fill.set_idx] <= fill.fill_tag;
	end

endmodule

`default_nettype wire

//--- dcache/dcache_data_stage.sv
// Data cache line memory, core port for hits and second port for L2 line transfers
`timescale 1ns/10ps
`default_nettype none

module dcache_data_stage import dcache_pkg::*;
(
	input wire clk,
	lookup_if.sink lookup,
	fill_if.line_xfer fill,
	output line_t data_o
);

	// 128 lines, way by set
	line_t line_mem [num_ways][num_sets];

	line_t core_line;
	line_t merged_line;
	logic core_write;
	logic core_read;

	assign core_line = line_mem[lookup.way][lookup.set_idx];
	assign core_write = lookup.hit_valid && lookup.write;
	assign core_read = lookup.hit_valid && !lookup.write;

	// Byte merge of the core write data
	always_comb
	begin
		for (int b = 0; b < line_bytes; b++)
		begin
			if (lookup.mask[b])
				merged_line[b*8 +: 8] = lookup.wdata[b*8 +: 8];
			else
				merged_line[b*8 +: 8] = core_line[b*8 +: 8];
		end
	end

	// Victim line read out at the fill address for write-back
	assign fill.victim_line = line_mem[fill.way][fill.set_idx];

	// Both write ports.  A fill never targets a line the core can hit,
	// since the tag stage invalidated it on fill start
	always_ff @(posedge clk)
	begin
		if (core_write)
			line_mem[lookup.way][lookup.set_idx] <= merged_line;
		if (fill.line_write)
			line_mem[fill.way][fill.set_idx] <= fill.fill_line;
	end

	// Read data holds until the next read hit
	always_ff @(posedge clk)
	begin
		if (core_read)
			data_o <= core_line;
	end

endmodule

`default_nettype wire

//--- dcache/miss_fifo.sv
// Miss FIFO, a small circular buffer of pending miss records
`timescale 1ns/10ps
`default_nettype none

module miss_fifo import dcache_pkg::*;
(
	input wire clk,
	input wire reset_i,
	miss_if.sink miss,
	output logic empty_o,
	input wire dequeue_i,
	output miss_rec_t head_o
);

	miss_rec_t entries [fifo_depth];
	logic [$clog2(fifo_depth)-1:0] wr_ptr;
	logic [$clog2(fifo_depth)-1:0] rd_ptr;
	logic [$clog2(fifo_depth):0] count;
	logic full;
	logic push;
	logic pop;

	assign full = int'(count) == fifo_depth;
	assign empty_o = count == '0;
	// Misses arriving when full are dropped, the core retries
	assign push = miss.enqueue && !full;
	assign pop = dequeue_i && !empty_o;
	assign head_o = entries[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (push)
			entries[wr_ptr] <= miss.rec;
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- dcache/l2_miss_ctrl.sv
// L2 miss controller, writes back dirty victims and fetches missed lines
`timescale 1ns/10ps
`default_nettype none

module l2_miss_ctrl import dcache_pkg::*;
(
	input wire clk,
	input wire reset_i,
	input wire empty_i,
	input wire miss_rec_t head_i,
	output logic dequeue_o,
	fill_if.source fill,
	output logic l2_read_o,
	output logic l2_write_o,
	output addr_t l2_addr_o,
	input wire l2_ack_i,
	input wire line_t l2_data_i,
	output line_t l2_data_o
);

	miss_state_t state_q;
	miss_state_t state_next;
	logic read_done;

	always_comb
	begin
		state_next = state_q;
		case (state_q)
			idle:
			begin
				if (!empty_i)
					state_next = head_i.victim_dirty ? l2_write : l2_read;
			end
			l2_write:
			begin
				if (l2_ack_i)
					state_next = l2_read;
			end
			l2_read:
			begin
				if (l2_ack_i)
					state_next = idle;
			end
			default:
				state_next = idle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
			state_q <= idle;
		else
			state_q <= state_next;
	end

	// Strobes come from the state register and stay steady over L2 stalls
	assign l2_write_o = state_q == l2_write;
	assign l2_read_o = state_q == l2_read;
	assign l2_addr_o = l2_write_o ? {head_i.victim_tag, head_i.set_idx, 6'b0}
		: {head_i.req_tag, head_i.set_idx, 6'b0};
	assign l2_data_o = fill.victim_line;

	// Read data lands in the line on the acknowledge cycle
	assign read_done = l2_read_o && l2_ack_i;
	assign dequeue_o = read_done;

	assign fill.set_idx = head_i.set_idx;
	assign fill.way = head_i.victim_way;
	assign fill.fill_start = state_q == idle && !empty_i;
	assign fill.line_write = read_done;
	assign fill.fill_line = l2_data_i;
	assign fill.fill_done = read_done;
	assign fill.fill_tag = head_i.req_tag;

endmodule

`default_nettype wire

//--- dcache/data_cache.sv
// Level-one data cache top, 4 ways by 32 sets of 64-byte lines, write-back
`timescale 1ns/10ps
`default_nettype none

module data_cache import dcache_pkg::*;
(
	input wire clk,
	input wire reset_i,

	// Core side
	input wire addr_t address_i,
	input wire access_i,
	input wire write_i,
	input wire byte_mask_t write_mask_i,
	input wire line_t data_i,
	output wire line_t data_o,
	output wire cache_hit_o,

	// L2 side
	output wire l2_read_o,
	output wire l2_write_o,
	output wire addr_t l2_addr_o,
	input wire l2_ack_i,
	input wire line_t l2_data_i,
	output wire line_t l2_data_o
);

	lookup_if lookup_bus();
	miss_if miss_bus();
	fill_if fill_bus();

	// FIFO head to the miss controller
	logic fifo_empty;
	logic fifo_dequeue;
	miss_rec_t fifo_head;

	dcache_tag_stage tag_stage_i (
		.clk(clk),
		.reset_i(reset_i),
		.address_i(address_i),
		.access_i(access_i),
		.write_i(write_i),
		.write_mask_i(write_mask_i),
		.data_i(data_i),
		.cache_hit_o(cache_hit_o),
		.lookup(lookup_bus.source),
		.miss(miss_bus.source),
		.fill(fill_bus.bookkeep)
	);

	dcache_data_stage data_stage_i (
		.clk(clk),
		.lookup(lookup_bus.sink),
		.fill(fill_bus.line_xfer),
		.data_o(data_o)
	);

	miss_fifo miss_fifo_i (
		.clk(clk),
		.reset_i(reset_i),
		.miss(miss_bus.sink),
		.empty_o(fifo_empty),
		.dequeue_i(fifo_dequeue),
		.head_o(fifo_head)
	);

	l2_miss_ctrl miss_ctrl_i (
		.clk(clk),
		.reset_i(reset_i),
		.empty_i(fifo_empty),
		.head_i(fifo_head),
		.dequeue_o(fifo_dequeue),
		.fill(fill_bus.source),
		.l2_read_o(l2_read_o),
		.l2_write_o(l2_write_o),
		.l2_addr_o(l2_addr_o),
		.l2_ack_i(l2_ack_i),
		.l2_data_i(l2_data_i),
		.l2_data_o(l2_data_o)
	);

endmodule

`default_nettype wire

//--- bench/data_cache_tb.sv
// Data cache testbench with an L2 memory model and directed tests
`timescale 1ns/10ps
`default_nettype none

module data_cache_tb import dcache_pkg::*; ();

	logic clk = 1'b0;
	logic reset_i = 1'b1;
	addr_t address_i = '0;
	logic access_i = 1'b0;
	logic write_i = 1'b0;
	byte_mask_t write_mask_i = '0;
	line_t data_i = '0;
	wire line_t data_o;
	wire cache_hit_o;
	wire l2_read_o;
	wire l2_write_o;
	wire addr_t l2_addr_o;
	logic l2_ack_i = 1'b0;
	line_t l2_data_i = '0;
	wire line_t l2_data_o;

	integer seed = 32'h84f7be18;
	int l2_wait = -1;

	// L2 contents written back and the expected line contents
	line_t l2_mem [addr_t];
	line_t ref_mem [addr_t];
	addr_t wb_addr_q [$];
	line_t wb_line_q [$];
	addr_t rd_addr_q [$];

	// Reference model of tags and tree bits per set
	tag_t m_tag [num_sets][num_ways];
	logic m_valid [num_sets][num_ways];
	logic m_dirty [num_sets][num_ways];
	lru_bits_t m_lru [num_sets];

	data_cache data_cache_i (
		.clk(clk),
		.reset_i(reset_i),
		.address_i(address_i),
		.access_i(access_i),
		.write_i(write_i),
		.write_mask_i(write_mask_i),
		.data_i(data_i),
		.data_o(data_o),
		.cache_hit_o(cache_hit_o),
		.l2_read_o(l2_read_o),
		.l2_write_o(l2_write_o),
		.l2_addr_o(l2_addr_o),
		.l2_ack_i(l2_ack_i),
		.l2_data_i(l2_data_i),
		.l2_data_o(l2_data_o)
	);

	always #5 clk = !clk;

	// Default L2 line built from the line address
	function automatic line_t pattern_line(input addr_t line_addr);
		line_t l;
		for (int i = 0; i < 16; i++)
			l[i*32 +: 32] = line_addr ^ (32'h9e3779b9 * (i + 1));
		return l;
	endfunction

	function automatic line_t l2_stored(input addr_t line_addr);
		if (l2_mem.exists(line_addr))
			return l2_mem[line_addr];
		return pattern_line(line_addr);
	endfunction

	function automatic line_t ref_stored(input addr_t line_addr);
		if (ref_mem.exists(line_addr))
			return ref_mem[line_addr];
		return pattern_line(line_addr);
	endfunction

	function automatic line_t merge_bytes(input line_t old_line, input line_t new_line,
		input byte_mask_t mask);
		line_t l;
		for (int b = 0; b < line_bytes; b++)
			l[b*8 +: 8] = mask[b] ? new_line[b*8 +: 8] : old_line[b*8 +: 8];
		return l;
	endfunction

	// Tree walk where bit 0 picks the pair
	function automatic way_idx_t lru_victim(input lru_bits_t bits);
		if (!bits[0])
			return bits[1] ? 2'd1 : 2'd0;
		return bits[2] ? 2'd3 : 2'd2;
	endfunction

	task automatic lru_touch(input set_idx_t s, input way_idx_t way);
		if (way < 2'd2)
		begin
			m_lru[s][0] = 1'b1;
			m_lru[s][1] = way == 2'd0;
		end
		else
		begin
			m_lru[s][0] = 1'b0;
			m_lru[s][2] = way == 2'd2;
		end
	endtask

	function automatic logic model_lookup(input set_idx_t s, input tag_t t,
		output way_idx_t way);
		way = '0;
		for (int w = 0; w < num_ways; w++)
		begin
			if (m_valid[s][w] && m_tag[s][w] == t)
			begin
				way = way_idx_t'(w);
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	// Answers each strobe after 1 to 4 cycles
	always @(negedge clk)
	begin
		l2_ack_i = 1'b0;
		if (reset_i || !(l2_read_o || l2_write_o))
			l2_wait = -1;
		else
		begin
			if (l2_wait < 0)
				l2_wait = $random(seed) & 3;
			if (l2_wait > 0)
				l2_wait--;
			else
			begin
				l2_ack_i = 1'b1;
				l2_wait = -1;
				if (l2_write_o)
				begin
					l2_mem[l2_addr_o] = l2_data_o;
					wb_addr_q.push_back(l2_addr_o);
					wb_line_q.push_back(l2_data_o);
				end
				else
				begin
					l2_data_i = l2_stored(l2_addr_o);
					rd_addr_q.push_back(l2_addr_o);
				end
			end
		end
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input line_t expected, input line_t actual);
		if (expected !== actual)
			fail_run($sformatf("mismatch %s expected %0h actual %0h", name, expected, actual));
	endtask

	// Starts on a falling edge and returns in cycle 1
	task automatic issue_access(input addr_t addr, input logic wr, input byte_mask_t mask,
		input line_t wdata);
		address_i = addr;
		access_i = 1'b1;
		write_i = wr;
		write_mask_i = mask;
		data_i = wdata;
		@(negedge clk);
		access_i = 1'b0;
		write_i = 1'b0;
	endtask

	task automatic wait_l2_idle();
		int cycles;
		cycles = 0;
		while (!(l2_read_o || l2_write_o))
		begin
			@(negedge clk);
			cycles++;
			if (cycles > 20)
				fail_run("L2 request did not start after a miss");
		end
		cycles = 0;
		while (l2_read_o || l2_write_o)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > 50)
				fail_run("L2 interface did not return to idle");
		end
	endtask

	// One access with model prediction, refill and retry after a miss
	task automatic access_line(input string name, input addr_t addr, input logic wr,
		input byte_mask_t mask, input line_t wdata);
		addr_t line_addr;
		addr_t victim_addr;
		set_idx_t s;
		tag_t t;
		way_idx_t way;
		logic hit;
		int n_wb;
		int n_rd;
		line_addr = {addr[31:6], 6'h0};
		s = addr[10:6];
		t = addr[31:11];
		hit = model_lookup(s, t, way);
		n_wb = wb_addr_q.size();
		n_rd = rd_addr_q.size();
		issue_access(addr, wr, mask, wdata);
		check({name, " hit"}, line_t'(hit), line_t'(cache_hit_o));
		if (!hit)
		begin
			way = lru_victim(m_lru[s]);
			lru_touch(s, way);
			victim_addr = {m_tag[s][way], s, 6'h0};
			wait_l2_idle();
			if (m_valid[s][way] && m_dirty[s][way])
			begin
				check({name, " wb count"}, line_t'(n_wb + 1), line_t'(wb_addr_q.size()));
				check({name, " wb addr"}, line_t'(victim_addr), line_t'(wb_addr_q[n_wb]));
				check({name, " wb line"}, ref_stored(victim_addr), wb_line_q[n_wb]);
			end
			else
				check({name, " wb count"}, line_t'(n_wb), line_t'(wb_addr_q.size()));
			check({name, " read count"}, line_t'(n_rd + 1), line_t'(rd_addr_q.size()));
			check({name, " read addr"}, line_t'(line_addr), line_t'(rd_addr_q[n_rd]));
			m_tag[s][way] = t;
			m_valid[s][way] = 1'b1;
			m_dirty[s][way] = 1'b0;
			issue_access(addr, wr, mask, wdata);
			check({name, " retry hit"}, line_t'(1'b1), line_t'(cache_hit_o));
		end
		lru_touch(s, way);
		if (wr)
		begin
			ref_mem[line_addr] = merge_bytes(ref_stored(line_addr), wdata, mask);
			m_dirty[s][way] = 1'b1;
		end
		else
		begin
			@(negedge clk);
			check({name, " data"}, ref_stored(line_addr), data_o);
		end
	endtask

	task automatic check_reset_state();
		check("reset l2_read", '0, line_t'(l2_read_o));
		check("reset l2_write", '0, line_t'(l2_write_o));
		check("reset hit", '0, line_t'(cache_hit_o));
		access_line("first_access", 32'h0001_2345, 1'b0, '0, '0);
	endtask

	task automatic read_fill_and_hit();
		access_line("read_fill", 32'h8765_4380, 1'b0, '0, '0);
		access_line("read_hit", 32'h8765_43a4, 1'b0, '0, '0);
	endtask

	task automatic write_merge();
		access_line("merge_fill", 32'h0040_00c8, 1'b0, '0, '0);
		access_line("merge_write", 32'h0040_00c8, 1'b1, 64'h8000_0100_0000_0013,
			pattern_line(32'hc3c3_5a5a));
		access_line("merge_read", 32'h0040_00c8, 1'b0, '0, '0);
	endtask

	// Five tags in set 5 with the first one written before it is evicted
	task automatic dirty_eviction();
		addr_t a [5];
		for (int i = 0; i < 5; i++)
			a[i] = {21'h1a000 + 21'(i), 5'd5, 6'h0};
		access_line("evict_fill_a", a[0], 1'b0, '0, '0);
		access_line("evict_write_a", a[0], 1'b1, 64'hff00_0000_0000_00f0,
			pattern_line(32'h5555_0000));
		for (int i = 1; i < 4; i++)
			access_line("evict_fill", a[i], 1'b0, '0, '0);
		access_line("evict_dirty", a[4], 1'b0, '0, '0);
		access_line("evict_reread", a[0], 1'b0, '0, '0);
	endtask

	task automatic clean_eviction();
		int n_wb;
		n_wb = wb_addr_q.size();
		access_line("clean_new", {21'h1b000, 5'd5, 6'h0}, 1'b0, '0, '0);
		access_line("clean_evicted", {21'h1a002, 5'd5, 6'h0}, 1'b0, '0, '0);
		check("clean no wb", line_t'(n_wb), line_t'(wb_addr_q.size()));
	endtask

	initial
	begin
		for (int s = 0; s < num_sets; s++)
		begin
			m_lru[s] = '0;
			for (int w = 0; w < num_ways; w++)
			begin
				m_tag[s][w] = '0;
				m_valid[s][w] = 1'b0;
				m_dirty[s][w] = 1'b0;
			end
		end
		repeat (4) @(negedge clk);
		reset_i = 1'b0;
		check_reset_state();
		read_fill_and_hit();
		write_merge();
		dirty_eviction();
		clean_eviction();
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
common/dcache_pkg.sv
common/dcache_if.sv
dcache/pseudo_lru.sv
dcache/dcache_tag_stage.sv
dcache/dcache_data_stage.sv
dcache/miss_fifo.sv
dcache/l2_miss_ctrl.sv
dcache/data_cache.sv
bench/data_cache_tb.sv

//--- run_sim.sh
#!/bin/bash
# Build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module data_cache_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vdata_cache_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
	exit 0
fi
echo "Pass message not found"
exit 1
